// ==== design/rp_analog_pkg.sv ====
// Analog datapath package with sample widths, averaging constants and channel-pair types
`default_nettype none

package rp_analog_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int adc_w = 16;  // Raw word from the ADC pins
  localparam int smp_w = 14;  // Sample after the two reserved bits go
  localparam int sum_w = 15;  // Gen plus PID before clamping

  ////////////////////////////////////////
  // Moving average
  ////////////////////////////////////////

  localparam int avg_len   = 64;  // Samples in the window
  localparam int avg_shift = 6;   // log2 of avg_len
  localparam int acc_w     = 20;  // Holds 64 full-scale samples with sign

  ////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////

  // Two's complement sample
  typedef logic signed [smp_w-1:0] smp_t;

  // One sample per channel
  typedef struct packed {
    smp_t cha;
    smp_t chb;
  } smp_pair_t;

  // Raw ADC words as they arrive from the pins
  typedef struct packed {
    logic [adc_w-1:0] cha;  // Low two bits unused
    logic [adc_w-1:0] chb;
  } adc_raw_t;

  // Unsigned negative-slope codes for the DAC
  typedef struct packed {
    logic [smp_w-1:0] cha;
    logic [smp_w-1:0] chb;
  } dac_code_t;

  ////////////////////////////////////////
  // Code conversion
  ////////////////////////////////////////

  // Negative-slope code to two's complement and back again
  // Top bit passes through, the rest are inverted
  function automatic logic [smp_w-1:0] flip_slope(input logic [smp_w-1:0] code);
    return {code[smp_w-1], ~code[smp_w-2:0]};
  endfunction

endpackage : rp_analog_pkg

`default_nettype wire

// ==== design/adc_front.sv ====
// ADC front end that registers raw words, converts to two's complement and selects loopback
`timescale 1ns/1ps
`default_nettype none

module adc_front (
  input  wire                       adc_clk,
  input  wire                       adc_rstn,
  input  rp_analog_pkg::adc_raw_t   adc_raw_i,       // Raw words from the pins
  input  rp_analog_pkg::smp_pair_t  mix_dat_i,       // DAC-side samples
  input  wire                       digital_loop_i,  // Plain level without strobe
  output rp_analog_pkg::smp_pair_t  adc_dat_o
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // Input register
  ////////////////////////////////////////

  logic [smp_w-1:0] raw_a_q;  // Upper 14 bits only
  logic [smp_w-1:0] raw_b_q;

  smp_t conv_a;
  smp_t conv_b;

  // Should map onto IO block flops
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_raw_i.cha[adc_w-1 -: smp_w];  // Reserved LSBs dropped
      raw_b_q <= adc_raw_i.chb[adc_w-1 -: smp_w];
    end
  end

  ////////////////////////////////////////
  // Conversion and loopback
  ////////////////////////////////////////

  // Negative slope code into signed sample
  assign conv_a = $signed(flip_slope(raw_a_q));
  assign conv_b = $signed(flip_slope(raw_b_q));

  // Loopback bypasses the register entirely
  // so mixer output shows up in the same cycle
  always_comb begin
    if (digital_loop_i) begin
      adc_dat_o = mix_dat_i;  // Saturated gen + pid
    end else begin
      adc_dat_o.cha = conv_a;
      adc_dat_o.chb = conv_b;
    end
  end

endmodule : adc_front

`default_nettype wire

// ==== design/dac_mixer.sv ====
// DAC mixer that adds generator and controller samples per channel and clamps to 14 bits
`timescale 1ns/1ps
`default_nettype none

module dac_mixer (
  input  wire                       adc_clk,
  input  wire                       adc_rstn,
  input  rp_analog_pkg::smp_pair_t  gen_dat_i,  // Signal generator
  input  rp_analog_pkg::smp_pair_t  pid_dat_i,  // Controller output
  output rp_analog_pkg::smp_pair_t  mix_dat_o   // Registered and saturated
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // Sum and clamp
  ////////////////////////////////////////

  logic signed [sum_w-1:0] sum_a;  // One bit of headroom
  logic signed [sum_w-1:0] sum_b;

  // Clamp a 15-bit sum into the 14-bit signed range
  // Top two bits differ only on overflow
  function automatic smp_t clamp(input logic signed [sum_w-1:0] s);
    smp_t res;
    if (s[sum_w-1] != s[sum_w-2]) begin
      res = {s[sum_w-1], {(smp_w-1){~s[sum_w-1]}}};  // 8191 or -8192
    end else begin
      res = s[smp_w-1:0];
    end
    return res;
  endfunction

  // Operands sign extend to sum_w in this context
  assign sum_a = gen_dat_i.cha + pid_dat_i.cha;
  assign sum_b = gen_dat_i.chb + pid_dat_i.chb;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      mix_dat_o <= '0;
    end else begin
      mix_dat_o.cha <= clamp(sum_a);
      mix_dat_o.chb <= clamp(sum_b);
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Two 14-bit operands never reach past -16384 .. 16382
  assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    sum_a >= -(2**smp_w) && sum_a <= 2**smp_w - 2 &&
    sum_b >= -(2**smp_w) && sum_b <= 2**smp_w - 2)
    else $error("dac_mixer: sum outside operand range");

endmodule : dac_mixer

`default_nettype wire

// ==== design/boxcar_avg.sv ====
// Boxcar filter, 64-sample moving average per channel with ring buffer and running sum
`timescale 1ns/1ps
`default_nettype none

module boxcar_avg (
  input  wire                       adc_clk,
  input  wire                       adc_rstn,
  input  rp_analog_pkg::smp_pair_t  mix_dat_i,  // New sample every cycle
  output rp_analog_pkg::smp_pair_t  avg_dat_o   // Floor of window sum / 64
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  smp_t ring_mem [2][avg_len];  // History, index 0 is channel A

  logic [$clog2(avg_len)-1:0] wr_idx;  // Shared by both channels
  logic                       wrapped; // Set once every slot was written

  logic signed [acc_w-1:0] acc     [2];  // Running sums
  logic signed [acc_w-1:0] acc_nxt [2];
  smp_t                    din     [2];
  smp_t                    oldest  [2];  // Sample that leaves the window
  smp_t                    avg_q   [2];

  assign din[0] = mix_dat_i.cha;
  assign din[1] = mix_dat_i.chb;

  ////////////////////////////////////////
  // Running sum update
  ////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      // Unwritten slots count as zero
      oldest[ch]  = wrapped ? ring_mem[ch][wr_idx] : '0;
      acc_nxt[ch] = acc[ch] + din[ch] - oldest[ch];  // All signed
    end
  end

  ////////////////////////////////////////
  // Index and sums
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      wr_idx  <= '0;
      wrapped <= 1'b0;
      for (int ch = 0; ch < 2; ch++) begin
        acc[ch]   <= '0;
        avg_q[ch] <= '0;
      end
    end else begin
      if (wr_idx == avg_len - 1) begin
        wr_idx  <= '0;   // Wrap after 63
        wrapped <= 1'b1; // Stays set until next reset
      end else begin
        wr_idx <= wr_idx + 1'b1;
      end
      for (int ch = 0; ch < 2; ch++) begin
        acc[ch]   <= acc_nxt[ch];
        avg_q[ch] <= acc_nxt[ch][acc_w-1:avg_shift];  // Arithmetic floor divide
      end
    end
  end

  // Oldest slot is overwritten with the new sample
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      ring_mem[ch][wr_idx] <= din[ch];
    end
  end

  assign avg_dat_o.cha = avg_q[0];
  assign avg_dat_o.chb = avg_q[1];

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    wr_idx < avg_len)
    else $error("boxcar_avg: write index out of range");

  // Sum of 64 samples stays in 64x the sample range
  // so the shifted value always lands in smp_t
  assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    acc[0] >= -(2**(smp_w-1)) * avg_len && acc[0] <= (2**(smp_w-1) - 1) * avg_len &&
    acc[1] >= -(2**(smp_w-1)) * avg_len && acc[1] <= (2**(smp_w-1) - 1) * avg_len)
    else $error("boxcar_avg: running sum left sample range");

endmodule : boxcar_avg

`default_nettype wire

// ==== design/dac_encode.sv ====
// DAC encoder, turns averaged samples into negative-slope DAC codes and registers them
`timescale 1ns/1ps
`default_nettype none

module dac_encode (
  input  wire                       adc_clk,
  input  wire                       adc_rstn,
  input  rp_analog_pkg::smp_pair_t  avg_dat_i,  // Signed averaged samples
  output rp_analog_pkg::dac_code_t  dac_dat_o   // Unsigned, negative slope
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // Reset value is the code of a zero sample
  // which is 0 followed by thirteen ones
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_dat_o.cha <= flip_slope('0);
      dac_dat_o.chb <= flip_slope('0);
    end else begin
      dac_dat_o.cha <= flip_slope(avg_dat_i.cha);  // Same rule as the ADC side
      dac_dat_o.chb <= flip_slope(avg_dat_i.chb);
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Filter output is still zero on the first edge after release
  // so the DAC keeps sitting at mid-scale one cycle later
  assert property (@(posedge adc_clk)
    $rose(adc_rstn) |=> dac_dat_o == {2{flip_slope(smp_w'(0))}})
    else $error("dac_encode: DAC left mid-scale right after reset");

endmodule : dac_encode

`default_nettype wire

// ==== design/analog_top.sv ====
// Analog top, ADC front end plus the DAC mix, average and encode pipeline
`timescale 1ns/1ps
`default_nettype none

module analog_top (
  input  wire                       adc_clk,
  input  wire                       adc_rstn,        // Synchronous, active low
  // ADC side
  input  rp_analog_pkg::adc_raw_t   adc_raw_i,       // Raw pin words
  output rp_analog_pkg::smp_pair_t  adc_dat_o,       // To scope and PID
  // DAC side
  input  rp_analog_pkg::smp_pair_t  gen_dat_i,       // Generator samples
  input  rp_analog_pkg::smp_pair_t  pid_dat_i,       // Controller samples
  output rp_analog_pkg::dac_code_t  dac_dat_o,       // Both DAC codes
  // Configuration
  input  wire                       digital_loop_i   // DAC samples back into ADC path
);

  import rp_analog_pkg::*;

  smp_pair_t mix_dat;  // Saturated sum, also the loopback source
  smp_pair_t avg_dat;  // Moving average

  ////////////////////////////////////////
  // ADC input
  ////////////////////////////////////////

  adc_front i_adc_front (
    .adc_clk        (adc_clk       ),
    .adc_rstn       (adc_rstn      ),
    .adc_raw_i      (adc_raw_i     ),
    .mix_dat_i      (mix_dat       ),
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_dat_o     )
  );

  ////////////////////////////////////////
  // DAC pipeline, three stages
  ////////////////////////////////////////

  dac_mixer i_dac_mixer (
    .adc_clk   (adc_clk  ),
    .adc_rstn  (adc_rstn ),
    .gen_dat_i (gen_dat_i),
    .pid_dat_i (pid_dat_i),
    .mix_dat_o (mix_dat  )  // Stage 1
  );

  boxcar_avg i_boxcar_avg (
    .adc_clk   (adc_clk ),
    .adc_rstn  (adc_rstn),
    .mix_dat_i (mix_dat ),
    .avg_dat_o (avg_dat )  // Stage 2
  );

  dac_encode i_dac_encode (
    .adc_clk   (adc_clk  ),
    .adc_rstn  (adc_rstn ),
    .avg_dat_i (avg_dat  ),
    .dac_dat_o (dac_dat_o)  // Stage 3
  );

endmodule : analog_top

`default_nettype wire

// ==== bench/analog_checker.sv ====
// Analog datapath checker, cycle model of the ADC and DAC paths compared against the DUT
`timescale 1ns/1ps
`default_nettype none

module analog_checker (
  input  wire                       adc_clk,
  input  wire                       adc_rstn,
  input  rp_analog_pkg::adc_raw_t   adc_raw_i,
  input  rp_analog_pkg::smp_pair_t  gen_dat_i,
  input  rp_analog_pkg::smp_pair_t  pid_dat_i,
  input  wire                       digital_loop_i,
  input  rp_analog_pkg::smp_pair_t  adc_dat_i,   // DUT outputs under test
  input  rp_analog_pkg::dac_code_t  dac_dat_i,
  output int                        err_cnt_o,
  output int                        chk_cnt_o,   // Compared cycles
  output logic                      timeout_o
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // Model state
  int  raw_q [2];            // Upper 14 bits, unsigned
  int  mix_q [2];            // Saturated sums
  int  hist  [2][avg_len];   // Last 64 mixer outputs
  int  wsum  [2];            // Window sum
  int  avg_q [2];
  int  dac_q [2];            // DAC codes
  int  hidx;
  bit  model_ok = 1'b0;      // Set once reset was seen

  // Pin code to signed sample, top bit kept and the rest inverted
  function automatic int code_to_sample(input int code);
    int c;
    c = code ^ 8191;
    return (c >= 8192) ? c - 16384 : c;
  endfunction

  function automatic int sample_to_code(input int v);
    return (v & 16383) ^ 8191;  // Same rule backwards
  endfunction

  function automatic int saturate(input int s);
    if (s > 8191) return 8191;
    if (s < -8192) return -8192;
    return s;
  endfunction

  function automatic int floor_div(input int s);
    int q;
    q = s / avg_len;  // Truncates toward zero
    if (s < 0 && q * avg_len != s) q = q - 1;
    return q;
  endfunction

  ////////////////////////////////////////
  // One clock edge of the model
  task automatic step_model();
    int sa;
    int sb;
    if (!adc_rstn) begin
      for (int ch = 0; ch < 2; ch++) begin
        raw_q[ch] = 0;
        mix_q[ch] = 0;
        wsum[ch]  = 0;
        avg_q[ch] = 0;
        dac_q[ch] = sample_to_code(0);  // Mid-scale
        for (int k = 0; k < avg_len; k++) hist[ch][k] = 0;
      end
      hidx     = 0;
      model_ok = 1'b1;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        dac_q[ch] = sample_to_code(avg_q[ch]);  // Uses last cycle's average
        wsum[ch]  = wsum[ch] + mix_q[ch] - hist[ch][hidx];
        hist[ch][hidx] = mix_q[ch];
        avg_q[ch] = floor_div(wsum[ch]);
      end
      hidx = (hidx + 1) % avg_len;
      sa = $signed(gen_dat_i.cha);
      sb = $signed(pid_dat_i.cha);
      mix_q[0] = saturate(sa + sb);
      sa = $signed(gen_dat_i.chb);
      sb = $signed(pid_dat_i.chb);
      mix_q[1] = saturate(sa + sb);
      raw_q[0] = adc_raw_i.cha[15:2];  // Reserved bits dropped
      raw_q[1] = adc_raw_i.chb[15:2];
    end
  endtask

  task automatic check_field(input string port, input int exp_val, input logic [13:0] act);
    if (act !== exp_val[13:0]) begin
      err_cnt_o++;
      $display("Mismatch at %0t ns: %s expected 14'h%h, got 14'h%h",
               $time, port, exp_val[13:0], act);
    end
  endtask

  ////////////////////////////////////////
  // Compare mid high phase
  always @(posedge adc_clk) begin
    step_model();
    #2;
    if (model_ok) begin
      check_field("adc_dat_o.cha", digital_loop_i ? mix_q[0] : code_to_sample(raw_q[0]),
                  adc_dat_i.cha);
      check_field("adc_dat_o.chb", digital_loop_i ? mix_q[1] : code_to_sample(raw_q[1]),
                  adc_dat_i.chb);
      check_field("dac_dat_o.cha", dac_q[0], dac_dat_i.cha);
      check_field("dac_dat_o.chb", dac_q[1], dac_dat_i.chb);
      chk_cnt_o++;
    end
  end

  // Reset must come and go
  initial begin
    int n;
    bit seen_low;
    bit released;
    err_cnt_o = 0;
    chk_cnt_o = 0;
    timeout_o = 1'b0;
    n         = 0;
    seen_low  = 1'b0;
    released  = 1'b0;
    while (!released && n < 64) begin
      @(posedge adc_clk);
      if (adc_rstn === 1'b0) seen_low = 1'b1;
      else if (seen_low && adc_rstn === 1'b1) released = 1'b1;
      n++;
    end
    if (!released) begin
      $display("Timeout: adc_rstn was not released within 64 cycles");
      timeout_o = 1'b1;
    end
  end

endmodule : analog_checker

`default_nettype wire

// ==== bench/analog_tb.sv ====
// Analog datapath testbench that reads the case file and drives the DUT on falling edges
`timescale 1ns/1ps
`default_nettype none

module analog_tb;

  import rp_analog_pkg::*;

  logic      adc_clk;
  logic      adc_rstn;
  logic      digital_loop;
  adc_raw_t  adc_raw;
  smp_pair_t gen_dat;
  smp_pair_t pid_dat;
  smp_pair_t adc_dat;
  dac_code_t dac_dat;
  int        err_cnt;
  int        chk_cnt;
  logic      chk_timeout;
  logic [31:0] rng_state;
  int        case_ok;
  int        case_bad;

  always #4 adc_clk = ~adc_clk;  // 8 ns period

  analog_top DUT (
    .adc_clk        (adc_clk     ),
    .adc_rstn       (adc_rstn    ),
    .adc_raw_i      (adc_raw     ),
    .adc_dat_o      (adc_dat     ),
    .gen_dat_i      (gen_dat     ),
    .pid_dat_i      (pid_dat     ),
    .dac_dat_o      (dac_dat     ),
    .digital_loop_i (digital_loop)
  );

  analog_checker i_checker (
    .adc_clk        (adc_clk     ),
    .adc_rstn       (adc_rstn    ),
    .adc_raw_i      (adc_raw     ),
    .gen_dat_i      (gen_dat     ),
    .pid_dat_i      (pid_dat     ),
    .digital_loop_i (digital_loop),
    .adc_dat_i      (adc_dat     ),
    .dac_dat_i      (dac_dat     ),
    .err_cnt_o      (err_cnt     ),
    .chk_cnt_o      (chk_cnt     ),
    .timeout_o      (chk_timeout )
  );

  // Checker gave up waiting on reset
  always @(negedge adc_clk) begin
    if (chk_timeout) begin
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  function automatic logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  task automatic drive_fixed(input int lvl, input int ga, input int gb, input int pa,
                             input int pb, input logic [15:0] ra, input logic [15:0] rb);
    digital_loop = lvl[0];
    gen_dat.cha  = ga[13:0];
    gen_dat.chb  = gb[13:0];
    pid_dat.cha  = pa[13:0];
    pid_dat.chb  = pb[13:0];
    adc_raw.cha  = ra;
    adc_raw.chb  = rb;
  endtask

  // Full range draws with the top bit as sign
  task automatic drive_random(input int lvl);
    logic [15:0] r [7];
    for (int k = 0; k < 7; k++) r[k] = lcg_next();
    drive_fixed((lvl == 2) ? int'(r[6][15]) : lvl, $signed(r[0][13:0]), $signed(r[1][13:0]),
                $signed(r[2][13:0]), $signed(r[3][13:0]), r[4], r[5]);
  endtask

  // Called at time zero or right on a falling edge
  task automatic reset_dut();
    adc_rstn = 1'b0;
    drive_fixed(0, 0, 0, 0, 0, 16'h0, 16'h0);
    repeat (8) @(negedge adc_clk);
    adc_rstn = 1'b1;
  endtask

  task automatic wait_checked(input int target, output bit expired);
    int n;
    n = 0;
    while (chk_cnt < target && n < 40) begin
      @(negedge adc_clk);
      n++;
    end
    expired = (chk_cnt < target);
  endtask

  ////////////////////////////////////////
  // Case loop
  initial begin
    int fd;
    int cycles;
    int lvl;
    int ga;
    int gb;
    int pa;
    int pb;
    int errs_before;
    logic [15:0] ra;
    logic [15:0] rb;
    string line;
    string name;
    string mode;
    bit expired;
    adc_clk   = 1'b0;
    rng_state = 32'd29527;
    case_ok   = 0;
    case_bad  = 0;
    reset_dut();
    fd = $fopen("bench/analog_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open case file bench/analog_cases.txt");
      case_bad++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;
        if ($sscanf(line, "%s %s %d %d %d %d %d %h %h %d", name, mode, lvl, ga, gb,
                    pa, pb, ra, rb, cycles) != 10) begin
          $display("Malformed case line: %s", line);
          case_bad++;
          continue;
        end
        errs_before = err_cnt;
        if (mode == "step") reset_dut();  // Zero history
        for (int i = 0; i < cycles; i++) begin
          @(negedge adc_clk);
          if (mode == "random") drive_random(lvl);
          else drive_fixed((mode == "loop") ? 1 : lvl, ga, gb, pa, pb, ra, rb);
        end
        wait_checked(chk_cnt + 4, expired);  // Pipeline tail
        if (expired) begin
          $display("Timeout: checker stopped comparing during case %s", name);
          case_bad++;
          break;
        end
        if (err_cnt == errs_before) begin
          $display("[%0t] %s: %0d cycles, clean", $time, name, cycles);
          case_ok++;
        end else begin
          $display("[%0t] %s: %0d cycles, %0d mismatches", $time, name, cycles,
                   err_cnt - errs_before);
          case_bad++;
        end
      end
      $fclose(fd);
    end
    $display("Cases clean: %0d, failing: %0d, cycles compared: %0d, mismatches: %0d",
             case_ok, case_bad, chk_cnt, err_cnt);
    if (case_bad == 0 && err_cnt == 0 && case_ok > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : analog_tb

`default_nettype wire

// ==== bench/analog_cases.txt ====
# name mode loop gen_a gen_b pid_a pid_b raw_a raw_b cycles
# Samples in signed decimal, raw ADC words in hex, loop 2 toggles at random
rst_zero   const  0      0      0      0      0  0000 0000  10
adc_conv   random 0      0      0      0      0  0000 0000  100
adc_lowbit const  0      0      0      0      0  8003 7ffe  6
const_pos  const  0   1000   -500    234    -17  1234 abcd  70
sat_hi     const  0   8000   8191   1000   8191  0000 ffff  70
sat_lo     const  0  -8000  -8192  -1000  -8192  ffff 0000  70
step_pos   step   0   3000  -3000      0      0  4000 c000  70
step_odd   step   0    -77    129     -1      0  0000 0000  70
loop_on    loop   1   5000   6000   4000  -7000  aaaa 5555  20
loop_neg   loop   1  -4096     12  -4097   -100  1357 2468  10
random_mix random 2      0      0      0      0  0000 0000  300

// ==== rp_analog.f ====
design/rp_analog_pkg.sv
design/adc_front.sv
design/dac_mixer.sv
design/boxcar_avg.sv
design/dac_encode.sv
design/analog_top.sv
bench/analog_checker.sv
bench/analog_tb.sv
